// ==== include/sddr_macros.svh ====
`ifndef SDDR_MACROS_SVH
`define SDDR_MACROS_SVH

// Memory geometry
`define BANK_BITS       3
`define ROW_BITS        13
`define COL_BITS        10
`define WORD_BITS       16
`define BURST_LEN       8

// Byte address is {bank, row, column, byte}
`define ADDR_BITS       27
`define DDR_ADDR_BITS   14

// DDR3 timing in ddr_clock_i cycles
`define T_RCD           3       // ACTIVATE to READ/WRITE
`define T_RP            4       // Precharge period
`define T_RFC           12      // REFRESH to next command
`define T_REFI          400     // Refresh interval
`define CAS_LAT         5
`define CAS_WR_LAT      5
`define WR_RECOVERY     5

`endif

// ==== verilog/sddr_pkg.sv ====
`include "sddr_macros.svh"

package sddr_pkg;

    typedef logic [`ADDR_BITS-1:0] byte_addr_t;
    typedef logic [`WORD_BITS-1:0] word_t;
    typedef logic [`BURST_LEN*`WORD_BITS-1:0] burst_t;     // Word 0 in the low bits
    typedef logic [`BANK_BITS-1:0] bank_t;
    typedef logic [`DDR_ADDR_BITS-1:0] ddr_addr_t;

    // Bits are CS, RAS, CAS, WE, all active low
    typedef enum logic [3:0] {
        CMD_NOP      = 4'b0111,
        CMD_ACTIVATE = 4'b0011,
        CMD_READ     = 4'b0101,
        CMD_WRITE    = 4'b0100,
        CMD_REFRESH  = 4'b0001
    } ddr_cmd_t;

    typedef enum logic [2:0] {
        SEQ_IDLE,           // Bank precharged
        SEQ_ACTIVATE,
        SEQ_OP,
        SEQ_READ_WAIT,
        SEQ_WRITE_WAIT,
        SEQ_READ_END,
        SEQ_WRITE_END
    } seq_state_t;

endpackage

// ==== verilog/wb_burst_port.sv ====
module wb_burst_port (
    input  logic                 ddr_clock_i,
    input  logic                 rst_i,

    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  sddr_pkg::byte_addr_t wb_adr_i,
    input  sddr_pkg::burst_t     wb_dat_i,
    output sddr_pkg::burst_t     wb_dat_o,
    output logic                 wb_ack_o,

    input  logic                 op_done_i,
    input  sddr_pkg::burst_t     rd_data_i,

    output logic                 req_valid_o,
    output sddr_pkg::byte_addr_t req_addr_o,
    output logic                 req_write_o,
    output sddr_pkg::burst_t     req_data_o
);
    logic wait_stb_drop;    // Burst acked, master still holds stb
    logic accept;

    assign accept = wb_cyc_i && wb_stb_i && !req_valid_o && !wb_ack_o && !wait_stb_drop;

    // Read capture holds the burst stable until the next read
    assign wb_dat_o = rd_data_i;

    always_ff @(posedge ddr_clock_i) begin
        if (rst_i) begin
            req_valid_o   <= 1'b0;
            wb_ack_o      <= 1'b0;
            wait_stb_drop <= 1'b0;
        end else begin
            wb_ack_o <= 1'b0;
            if (op_done_i) begin
                wb_ack_o      <= 1'b1;
                req_valid_o   <= 1'b0;
                wait_stb_drop <= 1'b1;
            end else if (wait_stb_drop) begin
                if (!wb_cyc_i || !wb_stb_i)
                    wait_stb_drop <= 1'b0;
            end else if (accept) begin
                req_valid_o <= 1'b1;
            end
        end
    end

    // Command payload
    always_ff @(posedge ddr_clock_i) begin
        if (accept) begin
            req_addr_o  <= wb_adr_i;
            req_write_o <= wb_we_i;
            req_data_o  <= wb_dat_i;
        end
    end

endmodule

// ==== verilog/ddr_cmd_sequencer.sv ====
`include "sddr_macros.svh"

module ddr_cmd_sequencer (
    input  logic                 ddr_clock_i,
    input  logic                 rst_i,

    input  logic                 req_valid_i,
    input  sddr_pkg::byte_addr_t req_addr_i,
    input  logic                 req_write_i,

    input  logic                 refresh_pending_i,
    output logic                 refresh_grant_o,
    output logic                 op_done_o,
    output logic                 wr_load_o,
    output logic                 rd_sample_o,

    output logic                 ddr3_cke_o,
    output logic                 ddr3_cs_n_o,
    output logic                 ddr3_ras_n_o,
    output logic                 ddr3_cas_n_o,
    output logic                 ddr3_we_n_o,
    output sddr_pkg::bank_t      ddr3_ba_o,
    output sddr_pkg::ddr_addr_t  ddr3_addr_o,
    output logic                 ddr3_odt_o,
    output logic                 data_transfer_o,
    output logic                 data_write_o
);
    import sddr_pkg::*;

    localparam int COL_LSB   = $clog2(`WORD_BITS/8);
    localparam int ROW_LSB   = COL_LSB + `COL_BITS;
    localparam int BANK_LSB  = ROW_LSB + `ROW_BITS;
    localparam int HALF_BURST = `BURST_LEN/2;
    localparam int CNT_BITS  = $clog2(`T_RFC);

    seq_state_t           state;
    ddr_cmd_t             cmd_q;
    logic [CNT_BITS-1:0]  cnt;      // Cycles left before the state acts
    bank_t                req_bank;
    logic [`ROW_BITS-1:0] req_row;
    logic [`COL_BITS-1:0] req_col;

    assign req_bank = req_addr_i[BANK_LSB +: `BANK_BITS];
    assign req_row  = req_addr_i[ROW_LSB +: `ROW_BITS];
    assign req_col  = req_addr_i[COL_LSB +: `COL_BITS];

    assign {ddr3_cs_n_o, ddr3_ras_n_o, ddr3_cas_n_o, ddr3_we_n_o} = cmd_q;

    // Last cycle of the read burst
    assign rd_sample_o = (state == SEQ_READ_END) && (cnt == '0);

    always_ff @(posedge ddr_clock_i) begin
        if (rst_i) begin
            state           <= SEQ_IDLE;
            cnt             <= '0;
            cmd_q           <= CMD_NOP;
            ddr3_cke_o      <= 1'b0;
            ddr3_ba_o       <= '0;
            ddr3_addr_o     <= '0;
            ddr3_odt_o      <= 1'b0;
            data_transfer_o <= 1'b0;
            data_write_o    <= 1'b0;
            refresh_grant_o <= 1'b0;
            op_done_o       <= 1'b0;
            wr_load_o       <= 1'b0;
        end else begin
            ddr3_cke_o      <= 1'b1;
            cmd_q           <= CMD_NOP;
            ddr3_ba_o       <= '0;
            ddr3_addr_o     <= '0;
            refresh_grant_o <= 1'b0;
            op_done_o       <= 1'b0;
            wr_load_o       <= 1'b0;

            if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end else begin
                case (state)
                    SEQ_IDLE: begin
                        if (refresh_pending_i) begin    // Refresh wins over a request
                            cmd_q           <= CMD_REFRESH;
                            refresh_grant_o <= 1'b1;
                            cnt             <= CNT_BITS'(`T_RFC - 1);
                        end else if (req_valid_i) begin
                            state <= SEQ_ACTIVATE;
                        end
                    end
                    SEQ_ACTIVATE: begin
                        cmd_q       <= CMD_ACTIVATE;
                        ddr3_ba_o   <= req_bank;
                        ddr3_addr_o <= ddr_addr_t'(req_row);
                        cnt         <= CNT_BITS'(`T_RCD - 1);
                        state       <= SEQ_OP;
                    end
                    SEQ_OP: begin
                        ddr3_ba_o       <= req_bank;
                        ddr3_addr_o     <= ddr_addr_t'({1'b1, req_col});  // A10 auto-precharge
                        data_transfer_o <= 1'b1;
                        if (req_write_i) begin
                            cmd_q        <= CMD_WRITE;
                            ddr3_odt_o   <= 1'b1;
                            data_write_o <= 1'b1;
                            cnt          <= CNT_BITS'(`CAS_WR_LAT - 2);
                            state        <= SEQ_WRITE_WAIT;
                        end else begin
                            cmd_q <= CMD_READ;
                            cnt   <= CNT_BITS'(`CAS_LAT);
                            state <= SEQ_READ_WAIT;
                        end
                    end
                    SEQ_WRITE_WAIT: begin
                        wr_load_o <= 1'b1;      // Lanes start one cycle later
                        cnt       <= CNT_BITS'(HALF_BURST);
                        state     <= SEQ_WRITE_END;
                    end
                    SEQ_READ_WAIT: begin
                        cnt   <= CNT_BITS'(HALF_BURST - 1);
                        state <= SEQ_READ_END;
                    end
                    SEQ_WRITE_END: begin
                        ddr3_odt_o      <= 1'b0;
                        data_write_o    <= 1'b0;
                        data_transfer_o <= 1'b0;
                        op_done_o       <= 1'b1;
                        cnt             <= CNT_BITS'(`T_RP + `WR_RECOVERY - 1);
                        state           <= SEQ_IDLE;
                    end
                    SEQ_READ_END: begin
                        data_transfer_o <= 1'b0;
                        op_done_o       <= 1'b1;
                        cnt             <= CNT_BITS'(`T_RP - 1);
                        state           <= SEQ_IDLE;
                    end
                    default: state <= SEQ_IDLE;
                endcase
            end
        end
    end

endmodule

// ==== verilog/ddr_refresh_timer.sv ====
`include "sddr_macros.svh"

module ddr_refresh_timer (
    input  logic ddr_clock_i,
    input  logic rst_i,
    input  logic refresh_grant_i,
    output logic refresh_pending_o
);
    localparam int CNT_BITS = $clog2(`T_REFI + 1);

    logic [CNT_BITS-1:0] refi_cnt;

    always_ff @(posedge ddr_clock_i) begin
        if (rst_i) begin
            refi_cnt          <= CNT_BITS'(`T_REFI);
            refresh_pending_o <= 1'b0;
        end else if (refresh_grant_i) begin
            refi_cnt          <= CNT_BITS'(`T_REFI);
            refresh_pending_o <= 1'b0;
        end else if (refi_cnt == '0) begin
            refresh_pending_o <= 1'b1;      // Held until the sequencer grants
        end else begin
            refi_cnt <= refi_cnt - 1'b1;
        end
    end

endmodule

// ==== verilog/ddr_write_serializer.sv ====
`include "sddr_macros.svh"

module ddr_write_serializer (
    input  logic             ddr_clock_i,
    input  logic             rst_i,
    input  logic             wr_load_i,
    input  sddr_pkg::burst_t wr_data_i,
    output sddr_pkg::word_t  ddr3_dq0_o,
    output sddr_pkg::word_t  ddr3_dq1_o
);
    localparam int HALF_BURST = `BURST_LEN/2;
    localparam int LANE_BITS  = HALF_BURST*`WORD_BITS;

    logic [LANE_BITS-1:0] even_words;
    logic [LANE_BITS-1:0] odd_words;
    logic [LANE_BITS-1:0] lane0;
    logic [LANE_BITS-1:0] lane1;

    // Split the burst into even and odd words
    always_comb begin
        for (int i = 0; i < HALF_BURST; i++) begin
            even_words[i*`WORD_BITS +: `WORD_BITS] = wr_data_i[(2*i)*`WORD_BITS +: `WORD_BITS];
            odd_words[i*`WORD_BITS +: `WORD_BITS]  = wr_data_i[(2*i+1)*`WORD_BITS +: `WORD_BITS];
        end
    end

    always_ff @(posedge ddr_clock_i) begin
        if (rst_i) begin
            lane0 <= '0;
            lane1 <= '0;
        end else if (wr_load_i) begin
            lane0 <= even_words;
            lane1 <= odd_words;
        end else begin
            lane0 <= lane0 >> `WORD_BITS;   // Next word pair
            lane1 <= lane1 >> `WORD_BITS;
        end
    end

    assign ddr3_dq0_o = lane0[`WORD_BITS-1:0];
    assign ddr3_dq1_o = lane1[`WORD_BITS-1:0];

endmodule

// ==== verilog/ddr_read_capture.sv ====
module ddr_read_capture (
    input  logic             ddr_clock_i,
    input  logic             rst_i,
    input  logic             rd_sample_i,
    input  sddr_pkg::burst_t ddr3_dq_i,
    output sddr_pkg::burst_t rd_data_o
);
    // Holds the last read burst until the next sample
    always_ff @(posedge ddr_clock_i) begin
        if (rst_i)
            rd_data_o <= '0;
        else if (rd_sample_i)
            rd_data_o <= ddr3_dq_i;
    end

endmodule

// ==== verilog/sddr_ctrl_top.sv ====
module sddr_ctrl_top (
    input  logic                ddr_clock_i,
    input  logic                rst_i,

    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  logic                wb_we_i,
    input  sddr_pkg::byte_addr_t wb_adr_i,
    input  sddr_pkg::burst_t    wb_dat_i,
    output sddr_pkg::burst_t    wb_dat_o,
    output logic                wb_ack_o,

    output logic                ddr3_cke_o,
    output logic                ddr3_cs_n_o,
    output logic                ddr3_ras_n_o,
    output logic                ddr3_cas_n_o,
    output logic                ddr3_we_n_o,
    output logic                ddr3_odt_o,
    output sddr_pkg::bank_t     ddr3_ba_o,
    output sddr_pkg::ddr_addr_t ddr3_addr_o,
    output sddr_pkg::word_t     ddr3_dq0_o,
    output sddr_pkg::word_t     ddr3_dq1_o,
    input  sddr_pkg::burst_t    ddr3_dq_i,

    output logic                data_transfer_o,
    output logic                data_write_o
);
    import sddr_pkg::*;

    logic       req_valid;
    byte_addr_t req_addr;
    logic       req_write;
    burst_t     req_data;
    logic       op_done;
    logic       refresh_pending;
    logic       refresh_grant;
    logic       wr_load;
    logic       rd_sample;
    burst_t     rd_data;

    wb_burst_port u_port (
        .ddr_clock_i (ddr_clock_i),
        .rst_i       (rst_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .op_done_i   (op_done),
        .rd_data_i   (rd_data),
        .req_valid_o (req_valid),
        .req_addr_o  (req_addr),
        .req_write_o (req_write),
        .req_data_o  (req_data)
    );

    ddr_cmd_sequencer u_seq (
        .ddr_clock_i       (ddr_clock_i),
        .rst_i             (rst_i),
        .req_valid_i       (req_valid),
        .req_addr_i        (req_addr),
        .req_write_i       (req_write),
        .refresh_pending_i (refresh_pending),
        .refresh_grant_o   (refresh_grant),
        .op_done_o         (op_done),
        .wr_load_o         (wr_load),
        .rd_sample_o       (rd_sample),
        .ddr3_cke_o        (ddr3_cke_o),
        .ddr3_cs_n_o       (ddr3_cs_n_o),
        .ddr3_ras_n_o      (ddr3_ras_n_o),
        .ddr3_cas_n_o      (ddr3_cas_n_o),
        .ddr3_we_n_o       (ddr3_we_n_o),
        .ddr3_ba_o         (ddr3_ba_o),
        .ddr3_addr_o       (ddr3_addr_o),
        .ddr3_odt_o        (ddr3_odt_o),
        .data_transfer_o   (data_transfer_o),
        .data_write_o      (data_write_o)
    );

    ddr_refresh_timer u_refresh (
        .ddr_clock_i       (ddr_clock_i),
        .rst_i             (rst_i),
        .refresh_grant_i   (refresh_grant),
        .refresh_pending_o (refresh_pending)
    );

    ddr_write_serializer u_wr_ser (
        .ddr_clock_i (ddr_clock_i),
        .rst_i       (rst_i),
        .wr_load_i   (wr_load),
        .wr_data_i   (req_data),
        .ddr3_dq0_o  (ddr3_dq0_o),
        .ddr3_dq1_o  (ddr3_dq1_o)
    );

    ddr_read_capture u_rd_cap (
        .ddr_clock_i (ddr_clock_i),
        .rst_i       (rst_i),
        .rd_sample_i (rd_sample),
        .ddr3_dq_i   (ddr3_dq_i),
        .rd_data_o   (rd_data)
    );

endmodule

// ==== verification/sddr_sva.sv ====
`include "sddr_macros.svh"

module sddr_sva (
    input logic clk_i,
    input logic rst_i,
    input logic cs_n_i,
    input logic ras_n_i,
    input logic cas_n_i,
    input logic we_n_i,
    input logic wb_stb_i,
    input logic wb_ack_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import sddr_pkg::*;

    logic [3:0] cmd;
    logic [7:0] since_act;     // Saturating cycle counts
    logic [7:0] since_ref;

    assign cmd = {cs_n_i, ras_n_i, cas_n_i, we_n_i};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            since_act <= '1;
            since_ref <= '1;
        end else begin
            if (cmd == CMD_ACTIVATE)
                since_act <= 8'd1;
            else if (since_act != '1)
                since_act <= since_act + 1'b1;
            if (cmd == CMD_REFRESH)
                since_ref <= 8'd1;
            else if (since_ref != '1)
                since_ref <= since_ref + 1'b1;
        end
    end

    act_to_op: assert property (@(posedge clk_i) disable iff (rst_i)
        (cmd == CMD_READ || cmd == CMD_WRITE) |-> since_act >= 8'(`T_RCD))
        else $error("READ or WRITE too soon after ACTIVATE");

    refresh_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
        (cmd != CMD_NOP) |-> since_ref >= 8'(`T_RFC))
        else $error("Command issued within tRFC of REFRESH");

    ack_with_stb: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_ack_i |-> wb_stb_i)
        else $error("Wishbone ack without stb");

endmodule

// ==== verification/sddr_tb.sv ====
`include "sddr_macros.svh"

module sddr_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import sddr_pkg::*;

    localparam int NUM_ENTRIES = 8;
    localparam int ACK_TIMEOUT = 300;
    localparam int BURST_SLACK = 40;       // Longest burst that can delay a refresh
    localparam int WR_TO_NEXT  = 4 + `T_RP + `WR_RECOVERY;
    localparam int RD_TO_NEXT  = `CAS_LAT + 1 + 4 + `T_RP;

    logic ddr_clock_i;
    logic rst_i;
    logic wb_cyc_i;
    logic wb_stb_i;
    logic wb_we_i;
    byte_addr_t wb_adr_i;
    burst_t wb_dat_i;
    burst_t wb_dat_o;
    logic wb_ack_o;
    logic cke, cs_n, ras_n, cas_n, we_n, odt;
    bank_t ba;
    ddr_addr_t addr;
    word_t dq0, dq1;
    burst_t ddr3_dq_i = '0;
    logic data_transfer, data_write;
    logic [3:0] cmd;

    // Stimulus table
    logic       tbl_write [NUM_ENTRIES];
    byte_addr_t tbl_addr [NUM_ENTRIES];
    burst_t     tbl_data [NUM_ENTRIES];
    int         tbl_idle [NUM_ENTRIES];

    burst_t exp_mem [byte_addr_t];
    burst_t model [int];
    byte_addr_t cur_addr;
    burst_t cur_data, wr_capture;
    logic [31:0] lfsr_state;
    logic [`ROW_BITS-1:0] act_row;
    int cycle_n = 0, wr_cycle = -1000, rd_cycle = -1000, last_ref = 0, wr_key = 0;
    int act_cycle = -1000;
    int ack_count = 0, refresh_count = 0, mon_errors = 0, test_errors = 0, tests_run = 0;
    bit ref_seen = 0;
    bit in_wr;          // Inside a write burst window
    bit in_rd;          // Between READ and the read sample

    sddr_ctrl_top DUT (
        .ddr_clock_i(ddr_clock_i), .rst_i(rst_i),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
        .ddr3_cke_o(cke), .ddr3_cs_n_o(cs_n), .ddr3_ras_n_o(ras_n), .ddr3_cas_n_o(cas_n),
        .ddr3_we_n_o(we_n), .ddr3_odt_o(odt), .ddr3_ba_o(ba), .ddr3_addr_o(addr),
        .ddr3_dq0_o(dq0), .ddr3_dq1_o(dq1), .ddr3_dq_i(ddr3_dq_i),
        .data_transfer_o(data_transfer), .data_write_o(data_write)
    );

    bind sddr_ctrl_top sddr_sva u_sva (
        .clk_i(ddr_clock_i), .rst_i(rst_i), .cs_n_i(ddr3_cs_n_o), .ras_n_i(ddr3_ras_n_o),
        .cas_n_i(ddr3_cas_n_o), .we_n_i(ddr3_we_n_o), .wb_stb_i(wb_stb_i), .wb_ack_i(wb_ack_o)
    );

    assign cmd = {cs_n, ras_n, cas_n, we_n};

    initial begin
        ddr_clock_i = 1'b0;
        forever #10 ddr_clock_i = ~ddr_clock_i;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_burst(output burst_t b);
        for (int i = 0; i < $bits(burst_t); i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            b[i] = lfsr_state[0];
        end
    endtask

    // Byte address is {bank, row, column, byte}
    function automatic byte_addr_t make_addr(input int bank, input int row, input int col);
        return {bank_t'(bank), `ROW_BITS'(row), `COL_BITS'(col), 1'b0};
    endfunction

    function automatic word_t burst_word(input burst_t b, input int i);
        return b[i*`WORD_BITS +: `WORD_BITS];
    endfunction

    task automatic set_entry(input int i, input logic wr, input byte_addr_t a, input int idle);
        tbl_write[i] = wr;
        tbl_addr[i]  = a;
        tbl_idle[i]  = idle;
        tbl_data[i]  = '0;
        if (wr)
            random_burst(tbl_data[i]);
    endtask

    task automatic build_table();
        set_entry(0, 1'b1, make_addr(1, 5, 8), 0);
        set_entry(1, 1'b1, make_addr(6, 8190, 1016), 0);
        set_entry(2, 1'b0, make_addr(1, 5, 8), 0);
        set_entry(3, 1'b1, make_addr(3, 77, 64), 2);
        set_entry(4, 1'b0, make_addr(6, 8190, 1016), 0);
        set_entry(5, 1'b0, make_addr(3, 77, 64), 0);
        set_entry(6, 1'b0, make_addr(1, 5, 8), 1000);     // Long idle, refreshes run
        set_entry(7, 1'b0, make_addr(6, 8190, 1016), 0);
    endtask

    task automatic bus_error(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        mon_errors++;
    endtask

    task automatic test_error(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        test_errors++;
    endtask

    // DDR bus monitor and memory model
    always @(negedge ddr_clock_i) begin
        cycle_n++;
        if (rst_i) begin
            last_ref = cycle_n;
        end else begin
            if (cmd != CMD_NOP && ref_seen && cycle_n - last_ref < `T_RFC)
                bus_error("command within tRFC of REFRESH");
            if (cmd == CMD_ACTIVATE || cmd == CMD_REFRESH) begin
                if (cycle_n - wr_cycle < WR_TO_NEXT)
                    bus_error("ACTIVATE or REFRESH too soon after WRITE");
                if (cycle_n - rd_cycle < RD_TO_NEXT)
                    bus_error("ACTIVATE or REFRESH too soon after READ");
            end
            if (cmd == CMD_ACTIVATE) begin
                if (ba !== cur_addr[26:24] || addr !== ddr_addr_t'(cur_addr[23:11]))
                    bus_error($sformatf("ACTIVATE bank %0d row %0d", ba, addr));
                act_row = addr[`ROW_BITS-1:0];
                act_cycle = cycle_n;
            end else if (cmd == CMD_WRITE || cmd == CMD_READ) begin
                if (cycle_n - act_cycle < `T_RCD)
                    bus_error("READ or WRITE too soon after ACTIVATE");
                if (ba !== cur_addr[26:24] || addr[10] !== 1'b1
                        || addr[`COL_BITS-1:0] !== cur_addr[10:1])
                    bus_error($sformatf("column command bank %0d addr %h", ba, addr));
                if (cmd == CMD_WRITE) begin
                    wr_cycle = cycle_n;
                    wr_key = int'({ba, act_row, addr[`COL_BITS-1:0]});
                end else begin
                    rd_cycle = cycle_n;
                    ddr3_dq_i = model.exists(int'({ba, act_row, addr[`COL_BITS-1:0]})) ?
                        model[int'({ba, act_row, addr[`COL_BITS-1:0]})] : '0;
                end
            end else if (cmd == CMD_REFRESH) begin
                refresh_count++;
                ref_seen = 1'b1;
                last_ref = cycle_n;
            end
            if (cycle_n - last_ref > `T_REFI + BURST_SLACK) begin
                bus_error("no REFRESH within the refresh interval");
                last_ref = cycle_n;
            end
            in_wr = (cycle_n - wr_cycle <= `CAS_WR_LAT + 3);
            in_rd = (cycle_n - rd_cycle < `CAS_LAT + 1 + 4);
            if (odt !== in_wr || data_write !== in_wr)
                bus_error($sformatf("ODT %b write flag %b, expected %b", odt, data_write, in_wr));
            if (data_transfer !== (in_wr || in_rd))
                bus_error($sformatf("data_transfer %b, expected %b", data_transfer,
                                    in_wr || in_rd));
            if (cycle_n - wr_cycle >= `CAS_WR_LAT && cycle_n - wr_cycle < `CAS_WR_LAT + 4) begin
                if (dq0 !== burst_word(cur_data, 2*(cycle_n - wr_cycle - `CAS_WR_LAT))
                        || dq1 !== burst_word(cur_data, 2*(cycle_n - wr_cycle - `CAS_WR_LAT)+1))
                    bus_error($sformatf("write lanes carry %h/%h", dq0, dq1));
                wr_capture = {dq1, dq0, wr_capture[$bits(burst_t)-1:2*`WORD_BITS]};
                if (cycle_n - wr_cycle == `CAS_WR_LAT + 3)
                    model[wr_key] = wr_capture;
            end
            if (wb_ack_o) begin
                ack_count++;
                if (!wb_stb_i)
                    bus_error("ack while stb is low");
            end
        end
    end

    task automatic run_entry(input int idx);
        int errs_before;
        int acks_before;
        int refs_before;
        int waited;
        logic got_ack;
        errs_before = mon_errors + test_errors;
        refs_before = refresh_count;
        repeat (tbl_idle[idx]) @(negedge ddr_clock_i);
        acks_before = ack_count;
        cur_addr = tbl_addr[idx];
        cur_data = tbl_data[idx];
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = tbl_write[idx];
        wb_adr_i = tbl_addr[idx];
        wb_dat_i = tbl_data[idx];
        waited = 0;
        got_ack = 1'b0;
        while (!got_ack && waited < ACK_TIMEOUT) begin
            @(negedge ddr_clock_i);
            waited++;
            got_ack = wb_ack_o;
        end
        if (!got_ack) begin
            $display("Timeout: entry %0d got no ack within %0d cycles", idx, ACK_TIMEOUT);
            $display("RESULT: FAIL");
            $finish;
        end
        if (tbl_write[idx])
            exp_mem[tbl_addr[idx]] = tbl_data[idx];
        else if (wb_dat_o !== exp_mem[tbl_addr[idx]])
            test_error($sformatf("entry %0d read %h", idx, wb_dat_o));
        @(negedge ddr_clock_i);
        wb_cyc_i = 1'b0;                    // Drop on the cycle after ack
        wb_stb_i = 1'b0;
        repeat (4) @(negedge ddr_clock_i);
        if (ack_count != acks_before + 1)
            test_error($sformatf("entry %0d got %0d acks", idx, ack_count - acks_before));
        if (refresh_count - refs_before < tbl_idle[idx] / (`T_REFI + BURST_SLACK))
            test_error($sformatf("entry %0d saw too few refreshes", idx));
        tests_run++;
        $display("Entry %0d %s addr %h: %s", idx, tbl_write[idx] ? "write" : "read",
                 tbl_addr[idx], (mon_errors + test_errors == errs_before) ? "ok" : "errors");
    endtask

    initial begin
        rst_i = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        cur_addr = '0;
        cur_data = '0;
        wr_capture = '0;
        act_row = '0;
        lfsr_state = 32'h5444_7f06;
        build_table();
        repeat (10) @(posedge ddr_clock_i);
        @(negedge ddr_clock_i);
        rst_i = 1'b0;
        @(negedge ddr_clock_i);
        if (cke !== 1'b1 || cmd !== CMD_NOP || wb_ack_o !== 1'b0 || odt !== 1'b0
                || data_transfer !== 1'b0 || data_write !== 1'b0)
            test_error("state after reset");
        repeat (20) @(negedge ddr_clock_i);
        if (ack_count != 0)
            test_error("ack without a request");
        tests_run++;
        $display("Reset test: %s", (test_errors + mon_errors == 0) ? "ok" : "errors");
        for (int i = 0; i < NUM_ENTRIES; i++)
            run_entry(i);
        repeat (20) @(negedge ddr_clock_i);
        $display("Tests run %0d, refreshes %0d, errors %0d", tests_run, refresh_count,
                 mon_errors + test_errors);
        if (mon_errors + test_errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
verilog/sddr_pkg.sv
verilog/wb_burst_port.sv
verilog/ddr_cmd_sequencer.sv
verilog/ddr_refresh_timer.sv
verilog/ddr_write_serializer.sv
verilog/ddr_read_capture.sv
verilog/sddr_ctrl_top.sv
verification/sddr_sva.sv
verification/sddr_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= sddr_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= sources.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run check clean

all: check

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)

check: run
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
